// ==== logic/ooo_pkg.sv ====
package ooo_pkg;

	// Machine sizes
	localparam int NUM_PREGS = 64; // Physical registers, p0 hardwired to zero
	localparam int RS_DEPTH  = 16; // Reservation station rows
	localparam int NUM_FU    = 2;  // Integer ALUs

	typedef logic [31:0] word_t;
	typedef logic [5:0]  preg_t;
	typedef logic [6:0]  pc_t;
	typedef logic [3:0]  rs_idx_t;
	typedef logic        fu_t;

	// Major opcodes accepted at dispatch
	typedef enum logic [6:0] {
		OP_IMM = 7'b0010011, // ADDI, ANDI
		OP_REG = 7'b0110011  // ADD, SUB, XOR, SRA
	} opcode_e;

	// Decoded ALU operation
	typedef enum logic [2:0] {
		ADDI,
		ANDI,
		ADD,
		SUB,
		XOR,
		SRA,
		ILLEGAL
	} alu_op_e;

	// One reservation station row
	typedef struct packed {
		logic    in_use;
		alu_op_e alu_op;
		pc_t     pc;
		preg_t   dest;
		preg_t   src1;
		preg_t   src2;
		word_t   src1_data;
		word_t   src2_data;
		logic    src1_rdy;
		logic    src2_rdy;
		fu_t     fu;       // Unit the row is bound to
	} rs_row_t;

endpackage

// ==== logic/issue_if.sv ====
`timescale 1ns/1ps

interface issue_if;
	import ooo_pkg::*;

	// One issued instruction per unit
	logic [NUM_FU-1:0] valid; // Single-cycle strobe
	alu_op_e           alu_op [NUM_FU];
	word_t             src1   [NUM_FU]; // Operand values, not indices
	word_t             src2   [NUM_FU];
	preg_t             dest   [NUM_FU];
	pc_t               pc     [NUM_FU];

	modport rs_mp (
		output valid, alu_op, src1, src2, dest, pc
	);

	modport exe_mp (
		input valid, alu_op, src1, src2, dest, pc
	);

endinterface

// ==== logic/wakeup_if.sv ====
`timescale 1ns/1ps

interface wakeup_if;
	import ooo_pkg::*;

	// Result broadcast, one per ALU
	logic [NUM_FU-1:0] valid;
	preg_t             dest [NUM_FU];
	word_t             data [NUM_FU];
	pc_t               pc   [NUM_FU];

	modport exe_mp (output valid, dest, data, pc);

	// Register file writes the result and sets the ready bit
	modport rf_mp (input valid, dest, data);

	// Waiting rows capture matching operands
	modport rs_mp (input valid, dest, data);

endinterface

// ==== logic/preg_file.sv ====
`timescale 1ns/1ps

module preg_file (
	input  logic                  clock_i,
	input  logic                  rst_i,
	input  ooo_pkg::preg_t [3:0]  rd_addr_i,   // {ps2_2, ps1_2, ps2_1, ps1_1}
	output ooo_pkg::word_t [3:0]  rd_data_o,
	output logic [3:0]            rd_ready_o,
	input  logic [1:0]            clr_valid_i, // Accepted dispatch per slot
	input  ooo_pkg::preg_t [1:0]  clr_addr_i,
	wakeup_if.rf_mp               wb
);
	import ooo_pkg::*;

	word_t                data_q [NUM_PREGS];
	logic [NUM_PREGS-1:0] ready_q;

	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			for (int i = 0; i < NUM_PREGS; i++) begin
				data_q[i] <= '0;
			end
			ready_q <= '1;
		end else begin
			for (int k = 0; k < NUM_FU; k++) begin
				if (wb.valid[k] && wb.dest[k] != '0) begin
					data_q[wb.dest[k]]  <= wb.data[k];
					ready_q[wb.dest[k]] <= 1'b1;
				end
			end
			// A new producer wins over a broadcast to the same register
			for (int s = 0; s < 2; s++) begin
				if (clr_valid_i[s] && clr_addr_i[s] != '0) begin
					ready_q[clr_addr_i[s]] <= 1'b0;
				end
			end
		end
	end

	always_comb begin
		for (int r = 0; r < 4; r++) begin
			rd_data_o[r]  = data_q[rd_addr_i[r]];
			rd_ready_o[r] = ready_q[rd_addr_i[r]];
			for (int k = 0; k < NUM_FU; k++) begin
				if (wb.valid[k] && wb.dest[k] == rd_addr_i[r]) begin
					rd_data_o[r]  = wb.data[k]; // Same-cycle bypass
					rd_ready_o[r] = 1'b1;
				end
			end
			if (rd_addr_i[r] == '0) begin
				rd_data_o[r]  = '0;
				rd_ready_o[r] = 1'b1;
			end
		end
	end

	// Unique destinations mean both ALUs never retire into one register
	a_wb_dest_unique: assert property (@(posedge clock_i) disable iff (rst_i)
		(wb.valid[0] && wb.valid[1] && wb.dest[0] != '0) |-> (wb.dest[0] != wb.dest[1]));

endmodule

// ==== logic/dispatch_unit.sv ====
`timescale 1ns/1ps

module dispatch_unit (
	input  logic                    clock_i,
	input  logic                    rst_i,
	input  logic                    valid_1_i,
	input  logic [6:0]              opcode_1_i,
	input  logic [2:0]              func3_1_i,
	input  logic [6:0]              func7_1_i,
	input  ooo_pkg::preg_t          ps1_1_i,
	input  ooo_pkg::preg_t          ps2_1_i,
	input  ooo_pkg::preg_t          pd_1_i,
	input  logic [11:0]             imm_1_i,
	input  ooo_pkg::pc_t            pc_1_i,
	input  logic                    valid_2_i,
	input  logic [6:0]              opcode_2_i,
	input  logic [2:0]              func3_2_i,
	input  logic [6:0]              func7_2_i,
	input  ooo_pkg::preg_t          ps1_2_i,
	input  ooo_pkg::preg_t          ps2_2_i,
	input  ooo_pkg::preg_t          pd_2_i,
	input  logic [11:0]             imm_2_i,
	input  ooo_pkg::pc_t            pc_2_i,
	output logic [1:0]              slot_valid_o,
	output ooo_pkg::rs_row_t [1:0]  row_o,
	output ooo_pkg::preg_t [3:0]    rf_addr_o,
	input  ooo_pkg::word_t [3:0]    rf_data_i,
	input  logic [3:0]              rf_ready_i,
	input  logic [1:0]              accept_i
);
	import ooo_pkg::*;

	alu_op_e op_s [2];
	fu_t     fu_toggle; // Unit for the next accepted instruction

	function automatic alu_op_e decode(input logic [6:0] opcode, input logic [2:0] func3,
		input logic [6:0] func7);
		alu_op_e op;
		op = ILLEGAL;
		if (opcode == OP_IMM) begin
			case (func3)
				3'b000:  op = ADDI;
				3'b111:  op = ANDI;
				default: op = ILLEGAL;
			endcase
		end else if (opcode == OP_REG) begin
			case ({func7, func3})
				10'b0000000_000: op = ADD;
				10'b0100000_000: op = SUB;
				10'b0000000_100: op = XOR;
				10'b0100000_101: op = SRA;
				default:         op = ILLEGAL;
			endcase
		end
		return op;
	endfunction

	assign op_s[0] = decode(opcode_1_i, func3_1_i, func7_1_i);
	assign op_s[1] = decode(opcode_2_i, func3_2_i, func7_2_i);

	// Illegal opcodes are dropped here
	assign slot_valid_o[0] = valid_1_i && (op_s[0] != ILLEGAL);
	assign slot_valid_o[1] = valid_2_i && (op_s[1] != ILLEGAL);

	assign rf_addr_o = {ps2_2_i, ps1_2_i, ps2_1_i, ps1_1_i};

	always_comb begin
		row_o[0] = '{in_use: 1'b1, alu_op: op_s[0], pc: pc_1_i, dest: pd_1_i,
			src1: ps1_1_i, src2: ps2_1_i, src1_data: rf_data_i[0], src2_data: rf_data_i[1],
			src1_rdy: rf_ready_i[0], src2_rdy: rf_ready_i[1], fu: fu_toggle};
		row_o[1] = '{in_use: 1'b1, alu_op: op_s[1], pc: pc_2_i, dest: pd_2_i,
			src1: ps1_2_i, src2: ps2_2_i, src1_data: rf_data_i[2], src2_data: rf_data_i[3],
			src1_rdy: rf_ready_i[2], src2_rdy: rf_ready_i[3], fu: fu_toggle ^ accept_i[0]};
		if (op_s[0] == ADDI || op_s[0] == ANDI) begin
			row_o[0].src2      = '0; // Pinned to p0 so no broadcast can match
			row_o[0].src2_data = {20'b0, imm_1_i};
			row_o[0].src2_rdy  = 1'b1;
		end
		if (op_s[1] == ADDI || op_s[1] == ANDI) begin
			row_o[1].src2      = '0;
			row_o[1].src2_data = {20'b0, imm_2_i};
			row_o[1].src2_rdy  = 1'b1;
		end
		// Slot 2 reading slot 1's result must wait for its broadcast
		if (slot_valid_o[0] && pd_1_i != '0) begin
			if (row_o[1].src1 == pd_1_i) row_o[1].src1_rdy = 1'b0;
			if (row_o[1].src2 == pd_1_i) row_o[1].src2_rdy = 1'b0;
		end
	end

	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			fu_toggle <= 1'b0;
		end else begin
			fu_toggle <= fu_toggle ^ accept_i[0] ^ accept_i[1];
		end
	end

endmodule

// ==== logic/reservation_station.sv ====
`timescale 1ns/1ps

module reservation_station (
	input  logic                    clock_i,
	input  logic                    rst_i,
	input  logic [1:0]              slot_valid_i,
	input  ooo_pkg::rs_row_t [1:0]  row_i,
	output logic [1:0]              accept_o,
	output logic                    stall_o,
	issue_if.rs_mp                  iss,
	wakeup_if.rs_mp                 wb
);
	import ooo_pkg::*;

	rs_row_t             rows_q   [RS_DEPTH];
	rs_row_t             rows_eff [RS_DEPTH]; // Rows with this cycle's wakeup applied
	logic [RS_DEPTH-1:0] row_rdy;
	logic [1:0]          free_cnt;
	rs_idx_t             free_idx [2];
	logic [NUM_FU-1:0]   sel_found;
	rs_idx_t             sel_idx  [NUM_FU];

	// Wakeup, visible to select in the same cycle
	always_comb begin
		for (int i = 0; i < RS_DEPTH; i++) begin
			rows_eff[i] = rows_q[i];
			for (int k = 0; k < NUM_FU; k++) begin
				if (wb.valid[k] && !rows_q[i].src1_rdy && wb.dest[k] == rows_q[i].src1) begin
					rows_eff[i].src1_data = wb.data[k];
					rows_eff[i].src1_rdy  = 1'b1;
				end
				if (wb.valid[k] && !rows_q[i].src2_rdy && wb.dest[k] == rows_q[i].src2) begin
					rows_eff[i].src2_data = wb.data[k];
					rows_eff[i].src2_rdy  = 1'b1;
				end
			end
			row_rdy[i] = rows_eff[i].in_use && rows_eff[i].src1_rdy && rows_eff[i].src2_rdy;
		end
	end

	// Two lowest free rows
	always_comb begin
		free_cnt    = 2'd0;
		free_idx[0] = '0;
		free_idx[1] = '0;
		for (int i = 0; i < RS_DEPTH; i++) begin
			if (!rows_q[i].in_use) begin
				if (free_cnt == 2'd0) begin
					free_idx[0] = rs_idx_t'(i);
					free_cnt    = 2'd1;
				end else if (free_cnt == 2'd1) begin
					free_idx[1] = rs_idx_t'(i);
					free_cnt    = 2'd2;
				end
			end
		end
	end

	assign stall_o  = (free_cnt != 2'd2); // Rows freed by issue count next cycle
	assign accept_o = slot_valid_i & {2{!stall_o}};

	// Oldest-index select per unit
	always_comb begin
		for (int k = 0; k < NUM_FU; k++) begin
			sel_found[k] = 1'b0;
			sel_idx[k]   = '0;
			for (int i = 0; i < RS_DEPTH; i++) begin
				if (!sel_found[k] && row_rdy[i] && rows_eff[i].fu == fu_t'(k)) begin
					sel_found[k] = 1'b1;
					sel_idx[k]   = rs_idx_t'(i);
				end
			end
		end
	end

	always_comb begin
		for (int k = 0; k < NUM_FU; k++) begin
			iss.valid[k]  = sel_found[k];
			iss.alu_op[k] = rows_eff[sel_idx[k]].alu_op;
			iss.src1[k]   = rows_eff[sel_idx[k]].src1_data;
			iss.src2[k]   = rows_eff[sel_idx[k]].src2_data;
			iss.dest[k]   = rows_eff[sel_idx[k]].dest;
			iss.pc[k]     = rows_eff[sel_idx[k]].pc;
		end
	end

	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			for (int i = 0; i < RS_DEPTH; i++) begin
				rows_q[i].in_use <= 1'b0;
			end
		end else begin
			for (int i = 0; i < RS_DEPTH; i++) begin
				rows_q[i] <= rows_eff[i];
			end
			for (int k = 0; k < NUM_FU; k++) begin
				if (sel_found[k]) rows_q[sel_idx[k]].in_use <= 1'b0; // Issued row leaves
			end
			for (int s = 0; s < 2; s++) begin
				if (accept_o[s]) rows_q[free_idx[s]] <= row_i[s];
			end
		end
	end

	a_alloc_free: assert property (@(posedge clock_i) disable iff (rst_i)
		(accept_o[0] |-> !rows_q[free_idx[0]].in_use) and
		(accept_o[1] |-> !rows_q[free_idx[1]].in_use));

	a_alloc_distinct: assert property (@(posedge clock_i) disable iff (rst_i)
		(accept_o == 2'b11) |-> (free_idx[0] != free_idx[1]));

endmodule

// ==== logic/exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage (
	input  logic     clock_i,
	input  logic     rst_i,
	issue_if.exe_mp  iss,
	wakeup_if.exe_mp wb
);
	import ooo_pkg::*;

	function automatic word_t alu(input alu_op_e op, input word_t a, input word_t b);
		word_t r;
		case (op)
			ADDI, ADD: r = a + b;
			SUB:       r = a - b;
			ANDI:      r = a & b;
			XOR:       r = a ^ b;
			SRA:       r = word_t'($signed(a) >>> b[4:0]); // Shift amount from low 5 bits
			default:   r = '0;
		endcase
		return r;
	endfunction

	for (genvar k = 0; k < NUM_FU; k++) begin : g_lane
		logic    ex_valid;
		alu_op_e ex_op;
		word_t   ex_a;
		word_t   ex_b;
		preg_t   ex_dest;
		pc_t     ex_pc;
		logic    res_valid;
		word_t   res_data;
		preg_t   res_dest;
		pc_t     res_pc;

		always_ff @(posedge clock_i) begin
			if (rst_i) begin
				ex_valid  <= 1'b0;
				res_valid <= 1'b0;
			end else begin
				ex_valid  <= iss.valid[k];
				res_valid <= ex_valid;
			end
		end

		// Lane input register, then result register
		always_ff @(posedge clock_i) begin
			ex_op    <= iss.alu_op[k];
			ex_a     <= iss.src1[k];
			ex_b     <= iss.src2[k];
			ex_dest  <= iss.dest[k];
			ex_pc    <= iss.pc[k];
			res_data <= alu(ex_op, ex_a, ex_b);
			res_dest <= ex_dest;
			res_pc   <= ex_pc;
		end

		assign wb.valid[k] = res_valid;
		assign wb.data[k]  = res_data;
		assign wb.dest[k]  = res_dest;
		assign wb.pc[k]    = res_pc;
	end

endmodule

// ==== logic/ooo_issue_core.sv ====
`timescale 1ns/1ps

module ooo_issue_core (
	input  logic           clock,
	input  logic           rst_i,
	input  logic           disp_valid_1_i,
	input  logic [6:0]     opcode_1_i,
	input  logic [2:0]     func3_1_i,
	input  logic [6:0]     func7_1_i,
	input  ooo_pkg::preg_t ps1_1_i,
	input  ooo_pkg::preg_t ps2_1_i,
	input  ooo_pkg::preg_t pd_1_i,
	input  logic [11:0]    imm_1_i,
	input  ooo_pkg::pc_t   pc_1_i,
	input  logic           disp_valid_2_i,
	input  logic [6:0]     opcode_2_i,
	input  logic [2:0]     func3_2_i,
	input  logic [6:0]     func7_2_i,
	input  ooo_pkg::preg_t ps1_2_i,
	input  ooo_pkg::preg_t ps2_2_i,
	input  ooo_pkg::preg_t pd_2_i,
	input  logic [11:0]    imm_2_i,
	input  ooo_pkg::pc_t   pc_2_i,
	output logic           disp_stall_o,
	output logic           res_valid_1_o,
	output ooo_pkg::preg_t res_dest_1_o,
	output ooo_pkg::word_t res_data_1_o,
	output ooo_pkg::pc_t   res_pc_1_o,
	output logic           res_valid_2_o,
	output ooo_pkg::preg_t res_dest_2_o,
	output ooo_pkg::word_t res_data_2_o,
	output ooo_pkg::pc_t   res_pc_2_o
);
	import ooo_pkg::*;

	preg_t [3:0]   rf_addr;
	word_t [3:0]   rf_data;
	logic [3:0]    rf_ready;
	logic [1:0]    slot_valid;
	rs_row_t [1:0] rows;
	logic [1:0]    accept;

	issue_if  iss_bus ();
	wakeup_if wb_bus ();

	preg_file u_preg_file (
		.clock_i (clock), .rst_i (rst_i),
		.rd_addr_i (rf_addr), .rd_data_o (rf_data), .rd_ready_o (rf_ready),
		.clr_valid_i (accept), .clr_addr_i ({rows[1].dest, rows[0].dest}), // Pending producers
		.wb (wb_bus.rf_mp)
	);

	dispatch_unit u_dispatch (
		.clock_i (clock), .rst_i (rst_i),
		.valid_1_i (disp_valid_1_i), .opcode_1_i (opcode_1_i), .func3_1_i (func3_1_i),
		.func7_1_i (func7_1_i), .ps1_1_i (ps1_1_i), .ps2_1_i (ps2_1_i), .pd_1_i (pd_1_i),
		.imm_1_i (imm_1_i), .pc_1_i (pc_1_i),
		.valid_2_i (disp_valid_2_i), .opcode_2_i (opcode_2_i), .func3_2_i (func3_2_i),
		.func7_2_i (func7_2_i), .ps1_2_i (ps1_2_i), .ps2_2_i (ps2_2_i), .pd_2_i (pd_2_i),
		.imm_2_i (imm_2_i), .pc_2_i (pc_2_i),
		.slot_valid_o (slot_valid), .row_o (rows),
		.rf_addr_o (rf_addr), .rf_data_i (rf_data), .rf_ready_i (rf_ready),
		.accept_i (accept)
	);

	reservation_station u_rs (
		.clock_i (clock), .rst_i (rst_i),
		.slot_valid_i (slot_valid), .row_i (rows),
		.accept_o (accept), .stall_o (disp_stall_o),
		.iss (iss_bus.rs_mp), .wb (wb_bus.rs_mp)
	);

	exec_stage u_exec (
		.clock_i (clock), .rst_i (rst_i),
		.iss (iss_bus.exe_mp), .wb (wb_bus.exe_mp)
	);

	// Broadcast registers are the result outputs
	assign res_valid_1_o = wb_bus.valid[0];
	assign res_dest_1_o  = wb_bus.dest[0];
	assign res_data_1_o  = wb_bus.data[0];
	assign res_pc_1_o    = wb_bus.pc[0];
	assign res_valid_2_o = wb_bus.valid[1];
	assign res_dest_2_o  = wb_bus.dest[1];
	assign res_data_2_o  = wb_bus.data[1];
	assign res_pc_2_o    = wb_bus.pc[1];

endmodule

// ==== verification/tb_ooo_issue_core.sv ====
`timescale 1ns/1ps

module tb_ooo_issue_core;
	import ooo_pkg::*;

	localparam int SETUP_A   = 8;
	localparam int RAND_A    = 16;
	localparam int ILLEGAL_A = 4;
	localparam int CHAIN_A   = 10;
	localparam int SETUP_B   = 6;
	localparam int RAND_B    = 54;
	localparam int SETUP_C   = 2;
	localparam int CHAIN_C   = 38;
	localparam int TOTAL_INSTR = SETUP_A + RAND_A + ILLEGAL_A + CHAIN_A + SETUP_B + RAND_B +
		SETUP_C + CHAIN_C;
	localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 20 + 200;
	localparam int DRAIN_CYCLES    = RS_DEPTH * 20; // Full station of chained rows

	typedef struct packed {
		alu_op_e     op;
		preg_t       ps1;
		preg_t       ps2;
		preg_t       pd;
		logic [11:0] imm;
	} instr_t;

	logic clock;
	logic rst_i;
	logic disp_valid_1_i, disp_valid_2_i;
	logic [6:0] opcode_1_i, opcode_2_i;
	logic [2:0] func3_1_i, func3_2_i;
	logic [6:0] func7_1_i, func7_2_i;
	preg_t ps1_1_i, ps2_1_i, pd_1_i, ps1_2_i, ps2_2_i, pd_2_i;
	logic [11:0] imm_1_i, imm_2_i;
	pc_t pc_1_i, pc_2_i;
	logic disp_stall_o;
	logic res_valid_1_o, res_valid_2_o;
	preg_t res_dest_1_o, res_dest_2_o;
	word_t res_data_1_o, res_data_2_o;
	pc_t res_pc_1_o, res_pc_2_o;

	// Program-order model and per-register bookkeeping
	word_t model    [NUM_PREGS];
	word_t exp_data [NUM_PREGS];
	pc_t   exp_pc   [NUM_PREGS];
	logic  expected [NUM_PREGS];
	logic  seen     [NUM_PREGS];
	logic  timed    [NUM_PREGS]; // Latency must be exactly 2
	int    disp_cyc [NUM_PREGS];
	preg_t pd_of_pc [128];
	preg_t srcs [$];             // Registers that later instructions may read
	preg_t next_pd;
	pc_t   next_pc;
	int    outstanding, cyc, max_pc, value_errors, other_errors;
	logic  ooo_seen, stall_seen;
	integer seed;

	ooo_issue_core u_dut (.*);

	always #4 clock = ~clock;

	always @(posedge clock) cyc <= cyc + 1;

	function automatic word_t ref_alu(input alu_op_e op, input word_t a, input word_t b);
		word_t r;
		case (op)
			ADD, ADDI: r = a + b;
			SUB:       r = a - b;
			ANDI:      r = a & b;
			XOR:       r = a ^ b;
			SRA:       r = word_t'($signed(a) >>> b[4:0]);
			default:   r = '0;
		endcase
		return r;
	endfunction

	// Returns {func7, func3, opcode}
	function automatic logic [16:0] encode(input alu_op_e op);
		logic [16:0] e;
		case (op)
			ADDI:    e = {7'h00, 3'b000, OP_IMM};
			ANDI:    e = {7'h00, 3'b111, OP_IMM};
			ADD:     e = {7'h00, 3'b000, OP_REG};
			SUB:     e = {7'h20, 3'b000, OP_REG};
			XOR:     e = {7'h00, 3'b100, OP_REG};
			SRA:     e = {7'h20, 3'b101, OP_REG};
			default: e = {7'h00, 3'b001, OP_REG}; // SLL is not implemented
		endcase
		return e;
	endfunction

	function automatic preg_t pick_src();
		return srcs[$unsigned($random(seed)) % srcs.size()];
	endfunction

	function automatic alu_op_e rand_op();
		alu_op_e op;
		case ($unsigned($random(seed)) % 5)
			0:       op = ADD;
			1:       op = SUB;
			2:       op = XOR;
			3:       op = SRA;
			default: op = ANDI;
		endcase
		return op;
	endfunction

	function automatic instr_t fresh(input alu_op_e op, input preg_t ps1, input preg_t ps2);
		instr_t t;
		t.op = op;
		t.ps1 = ps1;
		t.ps2 = ps2;
		t.pd = next_pd;
		t.imm = 12'($random(seed));
		next_pd = next_pd + 6'd1;
		return t;
	endfunction

	task automatic compare_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_pc(input string name, input pc_t got, input pc_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic compare_preg(input string name, input preg_t got, input preg_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("error at %0t ns: %s is p%0d, expected p%0d", $time, name, got, exp);
		end
	endtask

	task automatic idle_inputs;
		disp_valid_1_i = 1'b0;
		disp_valid_2_i = 1'b0;
		{func7_1_i, func3_1_i, opcode_1_i} = '0;
		{func7_2_i, func3_2_i, opcode_2_i} = '0;
		{ps1_1_i, ps2_1_i, pd_1_i, imm_1_i, pc_1_i} = '0;
		{ps1_2_i, ps2_2_i, pd_2_i, imm_2_i, pc_2_i} = '0;
	endtask

	task automatic restart;
		@(negedge clock);
		rst_i = 1'b1;
		for (int i = 0; i < NUM_PREGS; i++) begin
			model[i] = '0;
			expected[i] = 1'b0;
			seen[i] = 1'b0;
			timed[i] = 1'b0;
		end
		srcs = {};
		srcs.push_back('0);
		next_pd = 6'd1;
		next_pc = '0;
		max_pc = -1;
		outstanding = 0;
		ooo_seen = 1'b0;
		stall_seen = 1'b0;
		repeat (5) @(negedge clock);
		rst_i = 1'b0;
	endtask

	task automatic record(input instr_t t, input pc_t pc, input logic is_timed);
		word_t b;
		if (t.op != ILLEGAL) begin
			b = (t.op == ADDI || t.op == ANDI) ? {20'b0, t.imm} : model[t.ps2];
			model[t.pd] = ref_alu(t.op, model[t.ps1], b);
			exp_data[t.pd] = model[t.pd];
			exp_pc[t.pd] = pc;
			pd_of_pc[pc] = t.pd;
			expected[t.pd] = 1'b1;
			timed[t.pd] = is_timed;
			disp_cyc[t.pd] = cyc + 1; // Accepted at the coming rising edge
			outstanding++;
			srcs.push_back(t.pd);
		end
	endtask

	// Holds the pair on the inputs until a cycle without stall
	task automatic dispatch_pair(input instr_t i1, input instr_t i2, input logic is_timed);
		logic done;
		done = 1'b0;
		while (!done) begin
			@(negedge clock);
			disp_valid_1_i = 1'b1;
			{func7_1_i, func3_1_i, opcode_1_i} = encode(i1.op);
			{ps1_1_i, ps2_1_i, pd_1_i, imm_1_i} = {i1.ps1, i1.ps2, i1.pd, i1.imm};
			pc_1_i = next_pc;
			disp_valid_2_i = 1'b1;
			{func7_2_i, func3_2_i, opcode_2_i} = encode(i2.op);
			{ps1_2_i, ps2_2_i, pd_2_i, imm_2_i} = {i2.ps1, i2.ps2, i2.pd, i2.imm};
			pc_2_i = next_pc + 7'd1;
			if (disp_stall_o) stall_seen = 1'b1;
			else done = 1'b1;
		end
		record(i1, pc_1_i, is_timed);
		record(i2, pc_2_i, is_timed);
		next_pc = next_pc + 7'd2;
	endtask

	task automatic run_setup(input int n, input logic is_timed);
		instr_t a, b;
		for (int i = 0; i < n; i += 2) begin
			a = fresh(ADDI, '0, '0);
			b = fresh(ADDI, '0, '0);
			dispatch_pair(a, b, is_timed);
		end
	endtask

	task automatic run_random(input int n);
		instr_t a, b;
		for (int i = 0; i < n; i += 2) begin
			a = fresh(rand_op(), pick_src(), pick_src());
			b = fresh(rand_op(), pick_src(), pick_src());
			dispatch_pair(a, b, 1'b0);
		end
	endtask

	// Each slot reads the result just before it, slot 2 the one from slot 1
	task automatic run_chain(input int n);
		instr_t a, b;
		for (int i = 0; i < n; i += 2) begin
			a = fresh(rand_op(), srcs[$], pick_src());
			b = fresh(rand_op(), a.pd, pick_src());
			dispatch_pair(a, b, 1'b0);
		end
	endtask

	task automatic run_illegal;
		instr_t a, b;
		a = fresh(ILLEGAL, pick_src(), pick_src());
		b = fresh(XOR, pick_src(), pick_src());
		dispatch_pair(a, b, 1'b0);
		a = fresh(SUB, pick_src(), pick_src());
		b = fresh(ILLEGAL, pick_src(), pick_src());
		dispatch_pair(a, b, 1'b0);
	endtask

	task automatic drain;
		int waited;
		waited = 0;
		@(negedge clock);
		idle_inputs();
		while (outstanding != 0 && waited < DRAIN_CYCLES) begin
			@(negedge clock);
			waited++;
		end
		for (int i = 1; i < NUM_PREGS; i++) begin
			if (expected[i] && !seen[i]) begin
				other_errors++;
				$display("p%0d (pc %0d) never produced a result", i, exp_pc[i]);
			end
		end
	endtask

	task automatic check_result(input int lane, input preg_t dest, input word_t data, input pc_t pc);
		if (!expected[dest]) begin
			other_errors++;
			$display("lane %0d returned p%0d at %0t ns, which no legal instruction writes",
				lane, dest, $time);
		end else if (seen[dest]) begin
			other_errors++;
			$display("lane %0d returned p%0d a second time at %0t ns", lane, dest, $time);
		end else begin
			seen[dest] = 1'b1;
			outstanding--;
			compare_word($sformatf("res_data_%0d_o", lane), data, exp_data[dest]);
			compare_pc($sformatf("res_pc_%0d_o", lane), pc, exp_pc[dest]);
			compare_preg($sformatf("res_dest_%0d_o", lane), dest, pd_of_pc[pc]);
			if (timed[dest] && cyc - disp_cyc[dest] != 2) begin
				other_errors++;
				$display("p%0d arrived %0d cycles after dispatch instead of 2",
					dest, cyc - disp_cyc[dest]);
			end
			if (int'(pc) < max_pc) ooo_seen = 1'b1;
			else max_pc = int'(pc);
		end
	endtask

	always @(negedge clock) begin
		if (!rst_i && res_valid_1_o) check_result(1, res_dest_1_o, res_data_1_o, res_pc_1_o);
		if (!rst_i && res_valid_2_o) check_result(2, res_dest_2_o, res_data_2_o, res_pc_2_o);
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		other_errors++;
		$display("Run timed out after %0d cycles, %0d results never arrived",
			WATCHDOG_CYCLES, outstanding);
		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		seed = 32'h769c9d96;
		clock = 1'b0;
		rst_i = 1'b1;
		cyc = 0;
		value_errors = 0;
		other_errors = 0;
		idle_inputs();

		// Setup values, random ops, illegal opcodes, then short chains
		restart();
		run_setup(SETUP_A, 1'b1);
		run_random(RAND_A);
		run_illegal();
		run_chain(CHAIN_A);
		drain();

		restart();
		run_setup(SETUP_B, 1'b0);
		run_random(RAND_B);
		drain();
		if (!ooo_seen) begin
			other_errors++;
			$display("The random mix returned every result in program order");
		end

		// One long chain backs up the station
		restart();
		run_setup(SETUP_C, 1'b0);
		run_chain(CHAIN_C);
		drain();
		if (!stall_seen) begin
			other_errors++;
			$display("disp_stall_o never rose while the long chain was dispatched");
		end

		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== build.f ====
logic/ooo_pkg.sv
logic/issue_if.sv
logic/wakeup_if.sv
logic/preg_file.sv
logic/dispatch_unit.sv
logic/reservation_station.sv
logic/exec_stage.sv
logic/ooo_issue_core.sv
verification/tb_ooo_issue_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_ooo_issue_core
FILELIST  = build.f
OBJDIR    = obj_dir
PASS_MSG  = Test OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
